//--- build.f
logic/dma_pkg.sv
logic/dma_packet_buffer.sv
logic/dma_resp_handler.sv
logic/dma_local_mem.sv
logic/dma_resp_top.sv
dv/dma_resp_sva.sv
dv/dma_resp_tb.sv

//--- dv/dma_resp_tb.sv
// Testbench for the DMA response path
// Stimulus table, flit builder, LFSR data, completion and memory checks
`default_nettype none

module dma_resp_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FIFO_DEPTH = 16;
  localparam int MEM_WORDS  = 64;
  localparam int CW         = dma_pkg::CONTENT_WIDTH;
  localparam int NUM_ROWS   = 11;

  typedef enum logic [1:0] {K_L2R, K_R2L, K_UNK} kind_e;

  // One packet per row, hold set means no wait before the next row
  typedef struct packed {
    kind_e                          kind;
    logic [dma_pkg::ID_WIDTH-1:0]   id;
    logic                           resp_last;
    logic [CW-1:0]                  addr;
    logic [7:0]                     len;
    logic                           hold;
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{K_L2R, 2'd1, 1'b1, 32'd0,  8'd0, 1'b0},
    '{K_R2L, 2'd2, 1'b1, 32'd4,  8'd5, 1'b0},
    // Split response, one pulse after the third part
    '{K_R2L, 2'd3, 1'b0, 32'd16, 8'd3, 1'b1},
    '{K_R2L, 2'd3, 1'b0, 32'd19, 8'd2, 1'b1},
    '{K_R2L, 2'd3, 1'b1, 32'd21, 8'd4, 1'b0},
    '{K_UNK, 2'd0, 1'b1, 32'd0,  8'd3, 1'b1},
    '{K_L2R, 2'd0, 1'b1, 32'd0,  8'd0, 1'b0},
    // Back-to-back burst above the buffer depth, last one wraps memory
    '{K_R2L, 2'd1, 1'b1, 32'd40, 8'd8, 1'b1},
    '{K_L2R, 2'd2, 1'b0, 32'd0,  8'd0, 1'b1},
    '{K_R2L, 2'd0, 1'b1, 32'd60, 8'd6, 1'b1},
    '{K_L2R, 2'd3, 1'b1, 32'd0,  8'd0, 1'b0}
  };

  logic                 clk;
  logic                 rst;
  dma_pkg::flit_t       noc_in;
  logic                 noc_valid;
  logic                 noc_ready;
  dma_pkg::ctrl_done_t  ctrl_done;
  logic [CW-1:0]        rd_addr;
  logic [CW-1:0]        rd_data;

  // Reference state
  logic [CW-1:0]        shadow [MEM_WORDS];
  logic                 written [MEM_WORDS];
  dma_pkg::flit_t       flits_q [$];
  dma_pkg::ctrl_done_t  exp_done_q [$];
  logic [15:0]          lfsr;
  int                   errors;
  int                   checks;
  int                   cycles;
  int                   limit;

  dma_resp_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .MEM_WORDS  (MEM_WORDS)
  ) dma_resp_top_inst (
    .clk         (clk),
    .rst         (rst),
    .noc_in_i    (noc_in),
    .noc_valid_i (noc_valid),
    .noc_ready_o (noc_ready),
    .ctrl_done_o (ctrl_done),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Data source and packet building
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [CW-1:0] rand_word();
    logic [CW-1:0] w;
    w = '0;
    for (int b = 0; b < CW; b++) begin
      w = {w[CW-2:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic logic [CW-1:0] make_hdr(input dma_pkg::packet_type_e t,
                                             input logic [dma_pkg::ID_WIDTH-1:0] id,
                                             input logic last);
    dma_pkg::hdr_t h;
    h = '0;
    h.packet_type = t;
    h.id = id;
    h.resp_last = last;
    return h;
  endfunction

  function automatic int flit_count(input row_t r);
    case (r.kind)
      K_L2R:   return 1;
      K_R2L:   return 3 + int'(r.len);
      default: return 1 + int'(r.len);
    endcase
  endfunction

  // Flits into flits_q, shadow memory updated
  task automatic build_flits(input row_t r);
    dma_pkg::flit_t f;
    int idx;
    flits_q.delete();
    f.flit_type = (r.kind == K_L2R) ? dma_pkg::SINGLE : dma_pkg::FIRST;
    case (r.kind)
      K_L2R:   f.content = make_hdr(dma_pkg::L2R_RESP, r.id, r.resp_last);
      K_R2L:   f.content = make_hdr(dma_pkg::R2L_RESP, r.id, r.resp_last);
      default: f.content = make_hdr(dma_pkg::packet_type_e'(4'h9), r.id, r.resp_last);
    endcase
    flits_q.push_back(f);
    if (r.kind == K_R2L) begin
      // Size word then start address
      f.flit_type = dma_pkg::MIDDLE;
      f.content = CW'(r.len);
      flits_q.push_back(f);
      f.content = r.addr;
      flits_q.push_back(f);
    end
    if (r.kind != K_L2R) begin
      for (int i = 0; i < int'(r.len); i++) begin
        f.flit_type = (i == int'(r.len) - 1) ? dma_pkg::LAST : dma_pkg::MIDDLE;
        f.content = rand_word();
        flits_q.push_back(f);
        if (r.kind == K_R2L) begin
          idx = int'((r.addr + CW'(i)) % MEM_WORDS);
          shadow[idx] = f.content;
          written[idx] = 1'b1;
        end
      end
    end
  endtask

  // Pulse expected only once the packet's last flit is in the buffer
  task automatic expect_done(input row_t r);
    dma_pkg::ctrl_done_t d;
    // L2R always completes, R2L only on the final part
    if (r.kind == K_L2R || (r.kind == K_R2L && r.resp_last)) begin
      d.en = 1'b1;
      d.pos = r.id;
      exp_done_q.push_back(d);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driving and checking
  ////////////////////////////////////////////////////////////////////////////

  // Ready only moves at the edge, so the mid-cycle value decides transfer
  task automatic send_flits(output int stall_n);
    logic taken;
    stall_n = 0;
    while (flits_q.size() > 0) begin
      noc_in = flits_q.pop_front();
      noc_valid = 1'b1;
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = noc_ready;
        if (!taken) begin
          stall_n++;
        end
        @(posedge clk);
        #1;
      end
    end
    noc_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_done_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_done(input dma_pkg::ctrl_done_t exp, input dma_pkg::ctrl_done_t got);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: completion pos %0d expected, got en %0b pos %0d",
               $time, exp.pos, got.en, got.pos);
      errors++;
    end
  endtask

  task automatic check_word(input int addr, input logic [CW-1:0] exp,
                            input logic [CW-1:0] got);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: word %0d expected %08h, got %08h", $time, addr, exp, got);
      errors++;
    end
  endtask

  // Completion is combinational, settled by the falling edge
  always @(negedge clk) begin
    if (!rst && ctrl_done.en === 1'b1) begin
      if (exp_done_q.size() == 0) begin
        $display("Unexpected completion pulse for position %0d at time %0t",
                 ctrl_done.pos, $time);
        errors++;
      end else begin
        check_done(exp_done_q.pop_front(), ctrl_done);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Run stopped after %0d cycles, %0d completion pulses never arrived",
               cycles, exp_done_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    int stall_n;
    int stalls;
    int total;
    noc_in = '0;
    noc_valid = 1'b0;
    rd_addr = '0;
    rst = 1'b1;
    lfsr = 16'd99;
    errors = 0;
    checks = 0;
    cycles = 0;
    stalls = 0;
    total = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      shadow[a] = '0;
      written[a] = 1'b0;
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += flit_count(ROWS[r]);
    end
    limit = 4 * total + 200;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      build_flits(ROWS[r]);
      send_flits(stall_n);
      expect_done(ROWS[r]);
      stalls += stall_n;
      if (!ROWS[r].hold) begin
        wait_drained();
      end
      $display("Row %0d: kind %0d id %0d, %0d flits, %0d stall cycles, %0d errors",
               r, ROWS[r].kind, ROWS[r].id, flit_count(ROWS[r]), stall_n, errors);
    end
    wait_drained();

    // Read back every word the responses wrote
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (written[a]) begin
        rd_addr = CW'(a);
        @(negedge clk);
        check_word(a, shadow[a], rd_data);
        @(posedge clk);
        #1;
      end
    end

    $display("Rows %0d, flits %0d, stall cycles %0d, checks %0d, errors %0d",
             NUM_ROWS, total, stalls, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/dma_resp_sva.sv
// Concurrent assertions for the response handler and packet buffer
// One checker module, bound once to each of the two blocks
`default_nettype none

module dma_resp_sva (
  input wire                  clk,
  input wire                  rst,
  input dma_pkg::resp_state_e state_i,
  input dma_pkg::bus_wr_t     bus_i,
  input dma_pkg::ctrl_done_t  done_i,
  input wire                  fire_i,
  input wire                  full_i,
  input wire                  push_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Memory writes only while bursting data
  write_in_data: assert property (@(posedge clk) disable iff (rst)
    bus_i.en |-> (state_i == dma_pkg::DATA))
    else $error("memory write outside DATA state");

  // Each completion cycle belongs to exactly one flit taken
  done_single: assert property (@(posedge clk) disable iff (rst)
    done_i.en |-> fire_i)
    else $error("completion strobe without a flit taken");

  // Buffer never accepts into a full array
  no_push_full: assert property (@(posedge clk) disable iff (rst)
    full_i |-> !push_i)
    else $error("flit accepted while buffer full");

  // FSM stays on its encoded states
  state_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(state_i) && (state_i inside {dma_pkg::IDLE, dma_pkg::GET_SIZE,
      dma_pkg::GET_ADDR, dma_pkg::DATA, dma_pkg::DISCARD}))
    else $error("handler state outside its encoding");

endmodule

bind dma_resp_handler dma_resp_sva handler_sva_inst (
  .clk(clk), .rst(rst), .state_i(state), .bus_i(bus_o), .done_i(ctrl_done_o),
  .fire_i(fire), .full_i(1'b0), .push_i(1'b0)
);

bind dma_packet_buffer dma_resp_sva buffer_sva_inst (
  .clk(clk), .rst(rst), .state_i(dma_pkg::IDLE), .bus_i('0), .done_i('0),
  .fire_i(1'b0), .full_i(full), .push_i(push)
);

`default_nettype wire

//--- logic/dma_resp_top.sv
// DMA response path top level
// Packet buffer, response handler and local memory
`default_nettype none

module dma_resp_top #(
  parameter int FIFO_DEPTH = 16,
  parameter int MEM_WORDS  = 64
) (
  input  wire                                clk,
  input  wire                                rst,

  // NoC input
  input  dma_pkg::flit_t                     noc_in_i,
  input  wire                                noc_valid_i,
  output logic                               noc_ready_o,

  // Completion strobe
  output dma_pkg::ctrl_done_t                ctrl_done_o,

  // Memory read port
  input  wire [dma_pkg::CONTENT_WIDTH-1:0]   rd_addr_i,
  output logic [dma_pkg::CONTENT_WIDTH-1:0]  rd_data_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////////////////////

  // Buffer to handler
  dma_pkg::flit_t    buf_flit;
  logic              buf_valid;
  logic              buf_ready;

  // Handler to memory
  dma_pkg::bus_wr_t  mem_bus;

  dma_packet_buffer #(
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) buffer_inst (
    .clk          (clk),
    .rst          (rst),
    .in_flit_i    (noc_in_i),
    .in_valid_i   (noc_valid_i),
    .in_ready_o   (noc_ready_o),
    .out_flit_o   (buf_flit),
    .out_valid_o  (buf_valid),
    .out_ready_i  (buf_ready)
  );

  dma_resp_handler handler_inst (
    .clk          (clk),
    .rst          (rst),
    .flit_i       (buf_flit),
    .valid_i      (buf_valid),
    .ready_o      (buf_ready),
    .bus_o        (mem_bus),
    .ctrl_done_o  (ctrl_done_o)
  );

  dma_local_mem #(
    .MEM_WORDS    (MEM_WORDS)
  ) mem_inst (
    .clk          (clk),
    .bus_i        (mem_bus),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o)
  );

endmodule

`default_nettype wire

//--- logic/dma_local_mem.sv
// Local word memory
// Write port from the response handler, combinational external read port
`default_nettype none

module dma_local_mem #(
  parameter int MEM_WORDS = 64
) (
  input  wire                                clk,

  // Handler write bus
  input  dma_pkg::bus_wr_t                   bus_i,

  // External read port
  input  wire [dma_pkg::CONTENT_WIDTH-1:0]   rd_addr_i,
  output logic [dma_pkg::CONTENT_WIDTH-1:0]  rd_data_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam logic [dma_pkg::CONTENT_WIDTH-1:0] WORDS =
    dma_pkg::CONTENT_WIDTH'(MEM_WORDS);

  logic [dma_pkg::CONTENT_WIDTH-1:0]  mem [MEM_WORDS];

  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;

  // Both addresses wrap on the word count
  assign wr_idx = IDX_W'(bus_i.addr % WORDS);
  assign rd_idx = IDX_W'(rd_addr_i % WORDS);

  // Write strobe needs enable and write enable together
  always_ff @(posedge clk) begin
    if (bus_i.en && bus_i.we) begin
      mem[wr_idx] <= bus_i.data;
    end
  end

  // Read without handshake
  assign rd_data_o = mem[rd_idx];

endmodule

`default_nettype wire

//--- logic/dma_resp_handler.sv
// Response handler FSM
// Decodes L2R and R2L responses, bursts data to memory, pulses completion
`default_nettype none

module dma_resp_handler (
  input  wire                  clk,
  input  wire                  rst,

  // From packet buffer
  input  dma_pkg::flit_t       flit_i,
  input  wire                  valid_i,
  output logic                 ready_o,

  // Local memory write bus
  output dma_pkg::bus_wr_t     bus_o,

  // Completion toward transfer table
  output dma_pkg::ctrl_done_t  ctrl_done_o
);

  ////////////////////////////////////////////////////////////////////////////
  // State and response context
  ////////////////////////////////////////////////////////////////////////////

  dma_pkg::resp_state_e                state;
  dma_pkg::resp_state_e                nxt_state;

  // Context of the packet in flight
  logic [dma_pkg::ID_WIDTH-1:0]        resp_id;
  logic [dma_pkg::ID_WIDTH-1:0]        nxt_resp_id;
  logic                                resp_last;
  logic                                nxt_resp_last;
  logic [dma_pkg::CONTENT_WIDTH-1:0]   resp_addr;
  logic [dma_pkg::CONTENT_WIDTH-1:0]   nxt_resp_addr;

  dma_pkg::hdr_t                       hdr;
  logic                                fire;
  logic                                pkt_end;

  // Header view of the head flit
  assign hdr = dma_pkg::hdr_t'(flit_i.content);

  // Flit taken this cycle
  assign fire = valid_i & ready_o;

  // Closes a packet
  assign pkt_end = (flit_i.flit_type == dma_pkg::LAST) ||
                   (flit_i.flit_type == dma_pkg::SINGLE);

  // Bus payload follows running address and head content
  assign bus_o.addr = resp_addr;
  assign bus_o.data = flit_i.content;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_state     = state;
    nxt_resp_id   = resp_id;
    nxt_resp_last = resp_last;
    nxt_resp_addr = resp_addr;

    ready_o         = 1'b0;
    bus_o.en        = 1'b0;
    bus_o.we        = 1'b0;
    ctrl_done_o.en  = 1'b0;
    ctrl_done_o.pos = '0;

    case (state)
      dma_pkg::IDLE: begin
        // One header per cycle
        ready_o = 1'b1;
        if (fire) begin
          nxt_resp_id   = hdr.id;
          nxt_resp_last = hdr.resp_last;
          if (hdr.packet_type == dma_pkg::L2R_RESP) begin
            // Transfer finished, report right away
            ctrl_done_o.en  = 1'b1;
            ctrl_done_o.pos = hdr.id;
          end else if (hdr.packet_type == dma_pkg::R2L_RESP) begin
            nxt_state = dma_pkg::GET_SIZE;
          end else if (flit_i.flit_type != dma_pkg::SINGLE) begin
            // Unknown type, drop up to its last flit
            nxt_state = dma_pkg::DISCARD;
          end
        end
      end

      dma_pkg::GET_SIZE: begin
        // Size word not checked
        ready_o = 1'b1;
        if (fire) begin
          nxt_state = dma_pkg::GET_ADDR;
        end
      end

      dma_pkg::GET_ADDR: begin
        ready_o = 1'b1;
        if (fire) begin
          nxt_resp_addr = flit_i.content;
          nxt_state     = dma_pkg::DATA;
        end
      end

      dma_pkg::DATA: begin
        ready_o = 1'b1;
        if (fire) begin
          // Write this word, step to the next address
          bus_o.en      = 1'b1;
          bus_o.we      = 1'b1;
          nxt_resp_addr = resp_addr + 1'b1;
          if (pkt_end) begin
            nxt_state = dma_pkg::IDLE;
            // Only the final packet of a response completes it
            if (resp_last) begin
              ctrl_done_o.en  = 1'b1;
              ctrl_done_o.pos = resp_id;
            end
          end
        end
      end

      dma_pkg::DISCARD: begin
        ready_o = 1'b1;
        if (fire && pkt_end) begin
          nxt_state = dma_pkg::IDLE;
        end
      end

      default: begin
        nxt_state = dma_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dma_pkg::IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  // Context only meaningful once a header has been seen
  always_ff @(posedge clk) begin
    resp_id   <= nxt_resp_id;
    resp_last <= nxt_resp_last;
    resp_addr <= nxt_resp_addr;
  end

endmodule

`default_nettype wire

//--- logic/dma_packet_buffer.sv
// Flit FIFO between NoC input and response handler
// Circular storage, occupancy count, head shown combinationally
`default_nettype none

module dma_packet_buffer #(
  parameter int FIFO_DEPTH = 16
) (
  input  wire                 clk,
  input  wire                 rst,

  // NoC side
  input  dma_pkg::flit_t      in_flit_i,
  input  wire                 in_valid_i,
  output logic                in_ready_o,

  // Handler side
  output dma_pkg::flit_t      out_flit_o,
  output logic                out_valid_o,
  input  wire                 out_ready_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  dma_pkg::flit_t     mem [FIFO_DEPTH];

  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;

  logic               full;
  logic               push;
  logic               pop;

  // Advance with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // Flow control
  assign full        = (count == CNT_W'(FIFO_DEPTH));
  assign in_ready_o  = ~full;
  assign out_valid_o = (count != '0);

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Head entry straight from the array
  assign out_flit_o = mem[rd_ptr];

  // Data array
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointer and count update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Occupancy unchanged on simultaneous push and pop
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/dma_pkg.sv
// DMA response path shared types
// Flit and header layouts, memory bus, completion strobe, handler states
`default_nettype none

package dma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Flit payload, also bus address and data width
  localparam int CONTENT_WIDTH = 32;
  // Transfer table position, four entries
  localparam int ID_WIDTH = 2;
  // Packet type field at the top of a header
  localparam int PTYPE_WIDTH = 4;

  ////////////////////////////////////////////////////////////////////////////
  // NoC flits
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SINGLE = 2'b11,
    FIRST  = 2'b01,
    MIDDLE = 2'b00,
    LAST   = 2'b10
  } flit_type_e;

  typedef struct packed {
    flit_type_e                 flit_type;
    logic [CONTENT_WIDTH-1:0]   content;
  } flit_t;

  // Packet types carried in the header
  typedef enum logic [PTYPE_WIDTH-1:0] {
    L2R_REQ  = 4'h0,
    R2L_REQ  = 4'h1,
    L2R_RESP = 4'h2,
    R2L_RESP = 4'h3
  } packet_type_e;

  // Header content overlay
  typedef struct packed {
    packet_type_e                                packet_type;
    logic [ID_WIDTH-1:0]                         id;
    // Set on the final packet of a response
    logic                                        resp_last;
    logic [CONTENT_WIDTH-PTYPE_WIDTH-ID_WIDTH-2:0] rsvd;
  } hdr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Local side
  ////////////////////////////////////////////////////////////////////////////

  // Write bus toward the local memory
  typedef struct packed {
    logic                       en;
    logic                       we;
    logic [CONTENT_WIDTH-1:0]   addr;
    logic [CONTENT_WIDTH-1:0]   data;
  } bus_wr_t;

  // Completion strobe with table position
  typedef struct packed {
    logic                  en;
    logic [ID_WIDTH-1:0]   pos;
  } ctrl_done_t;

  // Response handler FSM
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    GET_SIZE = 3'd1,
    GET_ADDR = 3'd2,
    DATA     = 3'd3,
    DISCARD  = 3'd4
  } resp_state_e;

endpackage

`default_nettype wire
